//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_pkt_fifo
FILELIST = compile.f
OBJDIR   = obj_dir
RUNOPTS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) -Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(RUNOPTS) | \
		awk '{ print } /^Everything OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJDIR)

//--- compile.f
src/pkt_fifo_pkg.sv
src/cdc_sync.sv
src/pkt_ingress.sv
src/pkt_fifo_async.sv
src/pkt_egress.sv
src/pkt_fifo_top.sv
sim/pkt_fifo_chk.sv
sim/tb_pkt_fifo.sv

//--- sim/pkt_fifo_chk.sv
`timescale 1ns/100ps

module pkt_fifo_chk (
   input logic                    clk_in,
   input logic                    rst,
   input logic                    clk_out,
   input logic                    rst_out,
   input pkt_fifo_pkg::drop_cnt_t drop_count,
   input logic                    out_valid,
   input logic                    out_ready,
   input pkt_fifo_pkg::word_t     out_data,
   input pkt_fifo_pkg::keep_t     out_keep,
   input logic                    out_last
);

   // failed properties per clock domain
   int err_in  = 0;
   int err_out = 0;

   // total over both domains
   int err_count;

   assign err_count = err_in + err_out;

   // ----------------------------------------
   // output stream
   // ----------------------------------------

   // egress stays quiet while its reset is applied
   a_quiet_in_reset: assert property (@(posedge clk_out) rst_out |=> !out_valid)
      else begin
         $error("out_valid high while rst_out is applied");
         err_out = err_out + 1;
      end

   // a stalled word holds still until it is taken
   a_hold_on_stall: assert property (@(posedge clk_out) disable iff (rst_out)
      (out_valid && !out_ready) |=>
         (out_valid && $stable(out_data) && $stable(out_keep) && $stable(out_last)))
      else begin
         $error("output word changed while stalled");
         err_out = err_out + 1;
      end

   // ----------------------------------------
   // discard counter
   // ----------------------------------------

   // at most one drop per clk_in cycle
   a_drop_step: assert property (@(posedge clk_in) disable iff (rst)
      (drop_count != $past(drop_count)) |-> (drop_count == $past(drop_count) + 1'b1))
      else begin
         $error("drop_count moved by more than one");
         err_in = err_in + 1;
      end

endmodule

bind pkt_fifo_top pkt_fifo_chk i_pkt_fifo_chk (
   .clk_in     (clk_in),
   .rst        (rst),
   .clk_out    (clk_out),
   .rst_out    (rst_out),
   .drop_count (drop_count),
   .out_valid  (out_valid),
   .out_ready  (out_ready),
   .out_data   (out_data),
   .out_keep   (out_keep),
   .out_last   (out_last)
);

//--- sim/tb_pkt_fifo.sv
`timescale 1ns/100ps

module tb_pkt_fifo;

   // clocks start low
   logic                    clk_in = 1'b0;
   logic                    clk_out = 1'b0;

   // clk_in side
   logic                    rst;
   logic                    in_valid;
   pkt_fifo_pkg::word_t     in_data;
   pkt_fifo_pkg::keep_t     in_keep;
   logic                    in_last;
   pkt_fifo_pkg::drop_cnt_t drop_count;

   // clk_out side
   logic                    out_valid;
   logic                    out_ready;
   pkt_fifo_pkg::word_t     out_data;
   pkt_fifo_pkg::keep_t     out_keep;
   logic                    out_last;

   // reference model, expected output words oldest first
   pkt_fifo_pkg::word_t     exp_data [$];
   pkt_fifo_pkg::keep_t     exp_keep [$];
   logic                    exp_last [$];

   // out_ready behavior, 0 held low, 1 held high, 2 random stalls
   int                      ready_mode;

   always #4 clk_in = ~clk_in;
   always #5.5 clk_out = ~clk_out;

   pkt_fifo_top i_pkt_fifo_top (
      .clk_in     (clk_in),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_keep    (in_keep),
      .in_last    (in_last),
      .drop_count (drop_count),
      .clk_out    (clk_out),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_data   (out_data),
      .out_keep   (out_keep),
      .out_last   (out_last)
   );

   // ----------------------------------------
   // error handling and compares
   // ----------------------------------------

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("Something failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input string name, input pkt_fifo_pkg::word_t exp,
                             input pkt_fifo_pkg::word_t act);
      if (act !== exp) begin
         abort_run($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
      end
   endtask

   task automatic check_keep(input string name, input pkt_fifo_pkg::keep_t exp,
                             input pkt_fifo_pkg::keep_t act);
      if (act !== exp) begin
         abort_run($sformatf("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act));
      end
   endtask

   task automatic check_last(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         abort_run($sformatf("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act));
      end
   endtask

   task automatic check_drops(input string name, input pkt_fifo_pkg::drop_cnt_t exp,
                              input pkt_fifo_pkg::drop_cnt_t act);
      if (act !== exp) begin
         abort_run($sformatf("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act));
      end
   endtask

   // ----------------------------------------
   // input driver
   // ----------------------------------------

   task automatic drive_idle(input int n);
      repeat (n) begin
         @(posedge clk_in);
         #1;
         in_valid = 1'b0;
         in_last  = 1'b0;
      end
   endtask

   // word is taken at the following clk_in edge
   task automatic drive_word(input pkt_fifo_pkg::word_t d, input pkt_fifo_pkg::keep_t k,
                             input logic l);
      @(posedge clk_in);
      #1;
      in_valid = 1'b1;
      in_data  = d;
      in_keep  = k;
      in_last  = l;
   endtask

   task automatic push_expected(input pkt_fifo_pkg::word_t d, input pkt_fifo_pkg::keep_t k,
                                input logic l);
      exp_data.push_back(d);
      exp_keep.push_back(k);
      exp_last.push_back(l);
   endtask

   // partial mask for a final word, 1 to 4 bytes
   function automatic pkt_fifo_pkg::keep_t pick_last_keep();
      return pkt_fifo_pkg::keep_t'(4'hF >> $urandom_range(0, 3));
   endfunction

   // leaves in_valid high on the last word, caller ends or continues the burst
   task automatic send_packet(input int len, input pkt_fifo_pkg::keep_t last_keep,
                              input bit kept);
      pkt_fifo_pkg::word_t d;
      pkt_fifo_pkg::keep_t k;
      logic                l;
      for (int i = 0; i < len; i++) begin
         d = $urandom();
         l = (i == len - 1);
         k = l ? last_keep : 4'hF;
         if (kept) begin
            push_expected(d, k, l);
         end
         drive_word(d, k, l);
      end
   endtask

   // ----------------------------------------
   // output side
   // ----------------------------------------

   // ready changes just after the clk_out edge
   always @(posedge clk_out) begin
      #1;
      case (ready_mode)
         0:       out_ready = 1'b0;
         1:       out_ready = 1'b1;
         default: out_ready = ($urandom_range(0, 1) == 1);
      endcase
   end

   // mid cycle sample, the transfer happens at the coming edge
   always @(negedge clk_out) begin
      if (out_valid === 1'b1 && out_ready === 1'b1) begin
         if (exp_data.size() == 0) begin
            abort_run("an output word appeared while no word was expected");
         end else begin
            check_word("out_data", exp_data.pop_front(), out_data);
            check_keep("out_keep", exp_keep.pop_front(), out_keep);
            check_last("out_last", exp_last.pop_front(), out_last);
         end
      end
   end

   // bound assertions
   always @(posedge clk_in) begin
      if (i_pkt_fifo_top.i_pkt_fifo_chk.err_count != 0) begin
         abort_run("a bound assertion on the top level failed");
      end
   end

   // ----------------------------------------
   // waits
   // ----------------------------------------

   task automatic wait_drained(input int limit);
      int cycles;
      cycles = 0;
      while (exp_data.size() != 0) begin
         @(posedge clk_in);
         cycles++;
         if (cycles > limit) begin
            abort_run("timed out waiting for the expected words to come out");
         end
      end
      // read pointer crossing back to the write side
      drive_idle(10);
   endtask

   task automatic wait_room(input int len, input int limit);
      int cycles;
      cycles = 0;
      while (exp_data.size() + len > pkt_fifo_pkg::DEPTH) begin
         @(posedge clk_in);
         cycles++;
         if (cycles > limit) begin
            abort_run("timed out waiting for room in the buffer");
         end
      end
   endtask

   task automatic wait_out_valid(input int limit);
      int cycles;
      cycles = 0;
      while (out_valid !== 1'b1) begin
         @(negedge clk_out);
         cycles++;
         if (cycles > limit) begin
            abort_run("timed out waiting for out_valid");
         end
      end
   endtask

   // ----------------------------------------
   // tests
   // ----------------------------------------

   task automatic test_reset();
      rst = 1'b1;
      drive_idle(2);
      rst = 1'b0;
      // rst_out trails through two clk_out stages
      repeat (6) @(posedge clk_out);
      #1;
      check_last("out_valid", 1'b0, out_valid);
      check_drops("drop_count", '0, drop_count);
   endtask

   task automatic test_single_packet();
      pkt_fifo_pkg::drop_cnt_t base;
      base = drop_count;
      ready_mode = 1;
      send_packet(5, 4'h3, 1'b1);
      drive_idle(1);
      wait_drained(2000);
      check_drops("drop_count", base, drop_count);
   endtask

   task automatic test_store_forward();
      pkt_fifo_pkg::word_t d;
      ready_mode = 1;
      for (int i = 0; i < 4; i++) begin
         d = $urandom();
         push_expected(d, 4'hF, 1'b0);
         drive_word(d, 4'hF, 1'b0);
      end
      // packet held open, nothing may be released
      for (int c = 0; c < 40; c++) begin
         @(posedge clk_in);
         #1;
         in_valid = 1'b0;
         check_last("out_valid", 1'b0, out_valid);
      end
      d = $urandom();
      push_expected(d, 4'h7, 1'b1);
      drive_word(d, 4'h7, 1'b1);
      drive_idle(1);
      wait_drained(2000);
   endtask

   task automatic test_streaming();
      pkt_fifo_pkg::drop_cnt_t base;
      int                      len;
      base = drop_count;
      ready_mode = 2;
      for (int p = 0; p < 20; p++) begin
         len = $urandom_range(1, pkt_fifo_pkg::MAX_PKT_WORDS);
         wait_room(len, 5000);
         // gap lets the write side see the latest read pointer
         drive_idle(10);
         send_packet(len, pick_last_keep(), 1'b1);
         drive_idle(1);
      end
      wait_drained(20000);
      ready_mode = 1;
      check_drops("drop_count", base, drop_count);
   endtask

   task automatic test_overflow();
      pkt_fifo_pkg::drop_cnt_t base;
      int                      lens [7];
      int                      held;
      int                      dropped;
      bit                      fits;
      lens = '{5, 7, 6, 3, 4, 1, 2};
      base = drop_count;
      ready_mode = 0;
      repeat (2) @(posedge clk_out);
      // two words fill the egress stage, the buffer is then empty
      send_packet(2, 4'hF, 1'b1);
      drive_idle(1);
      wait_out_valid(200);
      drive_idle(10);
      held = 0;
      dropped = 0;
      // back to back, kept only if the whole packet fits
      foreach (lens[i]) begin
         fits = (held + lens[i] <= pkt_fifo_pkg::DEPTH);
         if (fits) begin
            held += lens[i];
         end else begin
            dropped++;
         end
         send_packet(lens[i], pick_last_keep(), fits);
      end
      drive_idle(1);
      // drop_count trails the last word by a cycle
      drive_idle(2);
      check_drops("drop_count", pkt_fifo_pkg::drop_cnt_t'(base + dropped), drop_count);
      ready_mode = 1;
      wait_drained(5000);
      check_drops("drop_count", pkt_fifo_pkg::drop_cnt_t'(base + dropped), drop_count);
   endtask

   task automatic test_oversize();
      pkt_fifo_pkg::drop_cnt_t base;
      base = drop_count;
      ready_mode = 1;
      send_packet(pkt_fifo_pkg::MAX_PKT_WORDS + 2, 4'hF, 1'b0);
      // next packet starts from the rewound boundary
      send_packet(6, pick_last_keep(), 1'b1);
      drive_idle(3);
      check_drops("drop_count", pkt_fifo_pkg::drop_cnt_t'(base + 1), drop_count);
      wait_drained(2000);
   endtask

   // ----------------------------------------
   // sequence
   // ----------------------------------------

   initial begin
      void'($urandom(93712));
      rst        = 1'b1;
      in_valid   = 1'b0;
      in_data    = '0;
      in_keep    = '0;
      in_last    = 1'b0;
      out_ready  = 1'b0;
      ready_mode = 0;
      test_reset();
      test_single_packet();
      test_store_forward();
      test_streaming();
      test_overflow();
      test_oversize();
      if (i_pkt_fifo_top.i_pkt_fifo_chk.err_count != 0) begin
         abort_run("a bound assertion on the top level failed");
      end else begin
         $display("Everything OK");
      end
      $finish;
   end

endmodule

//--- src/cdc_sync.sv
`timescale 1ns/100ps

module cdc_sync #(
   parameter int WIDTH = 1
) (
   input  logic             clk,
   input  logic [WIDTH-1:0] d,
   output logic [WIDTH-1:0] q
);

   // first stage may go metastable
   logic [WIDTH-1:0] meta;

   // ----------------------------------------
   // two flop synchronizer
   // ----------------------------------------

   // plain vector capture, only safe when at most one bit moves per step
   // gray pointers and single bit levels meet that
   always_ff @(posedge clk) begin
      meta <= d;
      q    <= meta;
   end

endmodule

//--- src/pkt_egress.sv
`timescale 1ns/100ps

module pkt_egress (
   input  logic                clk_out,
   input  logic                rst_out,

   // buffer head, fall-through
   input  logic                rd_avail,
   input  pkt_fifo_pkg::word_t rd_data,
   input  pkt_fifo_pkg::keep_t rd_keep,
   input  logic                rd_last,
   output logic                rd_en,

   // outgoing stream
   output logic                out_valid,
   input  logic                out_ready,
   output pkt_fifo_pkg::word_t out_data,
   output pkt_fifo_pkg::keep_t out_keep,
   output logic                out_last
);

   // two entry holding store
   pkt_fifo_pkg::word_t ent_data [2];
   pkt_fifo_pkg::keep_t ent_keep [2];
   logic                ent_last [2];

   // entry indices and occupancy, 0 to 2
   logic                wr_idx;
   logic                rd_idx;
   logic [1:0]          fill;

   // output transfer this cycle
   logic                pop;

   // ----------------------------------------
   // buffer side
   // ----------------------------------------

   // pull whenever a slot is free
   // out_ready stays out of this path on purpose
   assign rd_en = rd_avail & (fill != 2'd2);

   always_ff @(posedge clk_out) begin
      if (rd_en) begin
         ent_data[wr_idx] <= rd_data;
         ent_keep[wr_idx] <= rd_keep;
         ent_last[wr_idx] <= rd_last;
      end
   end

   // ----------------------------------------
   // stream side
   // ----------------------------------------

   assign out_valid = (fill != 2'd0);
   assign pop       = out_valid & out_ready;

   // head entry, held until accepted
   assign out_data = ent_data[rd_idx];
   assign out_keep = ent_keep[rd_idx];
   assign out_last = ent_last[rd_idx];

   always_ff @(posedge clk_out) begin
      if (rst_out) begin
         wr_idx <= 1'b0;
         rd_idx <= 1'b0;
         fill   <= 2'd0;
      end else begin
         if (rd_en) begin
            wr_idx <= ~wr_idx;
         end
         if (pop) begin
            rd_idx <= ~rd_idx;
         end
         case ({rd_en, pop})
            2'b10:   fill <= fill + 2'd1;
            2'b01:   fill <= fill - 2'd1;
            default: fill <= fill;
         endcase
      end
   end

endmodule

//--- src/pkt_fifo_async.sv
`timescale 1ns/100ps

module pkt_fifo_async (
   // write side, clk_in domain
   input  logic                clk_in,
   input  logic                rst,
   input  logic                wr_en,
   input  pkt_fifo_pkg::word_t wr_data,
   input  pkt_fifo_pkg::keep_t wr_keep,
   input  logic                wr_last,
   input  logic                commit,
   input  logic                rewind,
   output logic                full,

   // read side, clk_out domain
   input  logic                clk_out,
   input  logic                rst_out,
   input  logic                rd_en,
   output logic                rd_avail,
   output pkt_fifo_pkg::word_t rd_data,
   output pkt_fifo_pkg::keep_t rd_keep,
   output logic                rd_last
);

   // dual port storage, written in clk_in, read in clk_out
   pkt_fifo_pkg::word_t mem_data [pkt_fifo_pkg::DEPTH];
   pkt_fifo_pkg::keep_t mem_keep [pkt_fifo_pkg::DEPTH];
   logic                mem_last [pkt_fifo_pkg::DEPTH];

   // write domain pointers
   pkt_fifo_pkg::ptr_t  wr_ptr_spec;
   pkt_fifo_pkg::ptr_t  wr_ptr_spec_nxt;
   pkt_fifo_pkg::ptr_t  wr_ptr_cmt;
   pkt_fifo_pkg::ptr_t  wr_ptr_cmt_nxt;
   pkt_fifo_pkg::ptr_t  cmt_gray;
   pkt_fifo_pkg::ptr_t  rd_gray_sync;
   pkt_fifo_pkg::ptr_t  rd_ptr_wclk;

   // read domain pointers
   pkt_fifo_pkg::ptr_t  rd_ptr;
   pkt_fifo_pkg::ptr_t  rd_ptr_nxt;
   pkt_fifo_pkg::ptr_t  rd_gray;
   pkt_fifo_pkg::ptr_t  cmt_gray_sync;
   pkt_fifo_pkg::ptr_t  cmt_ptr_rclk;

   function automatic pkt_fifo_pkg::ptr_t bin2gray(input pkt_fifo_pkg::ptr_t b);
      return b ^ (b >> 1);
   endfunction

   function automatic pkt_fifo_pkg::ptr_t gray2bin(input pkt_fifo_pkg::ptr_t g);
      pkt_fifo_pkg::ptr_t b;
      b[pkt_fifo_pkg::ADDR_W] = g[pkt_fifo_pkg::ADDR_W];
      for (int i = pkt_fifo_pkg::ADDR_W - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // ----------------------------------------
   // write side
   // ----------------------------------------

   always_ff @(posedge clk_in) begin
      if (wr_en) begin
         mem_data[wr_ptr_spec[pkt_fifo_pkg::ADDR_W-1:0]] <= wr_data;
         mem_keep[wr_ptr_spec[pkt_fifo_pkg::ADDR_W-1:0]] <= wr_keep;
         mem_last[wr_ptr_spec[pkt_fifo_pkg::ADDR_W-1:0]] <= wr_last;
      end
   end

   // speculative pointer runs ahead, committed one marks the packet boundary
   always_comb begin
      wr_ptr_spec_nxt = wr_ptr_spec;
      wr_ptr_cmt_nxt  = wr_ptr_cmt;
      if (rewind) begin
         wr_ptr_spec_nxt = wr_ptr_cmt;
      end else if (wr_en) begin
         wr_ptr_spec_nxt = wr_ptr_spec + 1'b1;
      end
      // commit includes the last word written at this edge
      if (commit) begin
         wr_ptr_cmt_nxt = wr_ptr_spec_nxt;
      end
   end

   always_ff @(posedge clk_in) begin
      if (rst) begin
         wr_ptr_spec <= '0;
         wr_ptr_cmt  <= '0;
         cmt_gray    <= '0;
      end else begin
         wr_ptr_spec <= wr_ptr_spec_nxt;
         wr_ptr_cmt  <= wr_ptr_cmt_nxt;
         cmt_gray    <= bin2gray(wr_ptr_cmt_nxt);
      end
   end

   // only committed words are visible to the reader
   cdc_sync #(.WIDTH($bits(pkt_fifo_pkg::ptr_t))) i_cmt_sync (
      .clk (clk_out),
      .d   (cmt_gray),
      .q   (cmt_gray_sync)
   );

   // full against the speculative pointer, rewound space frees at once
   assign rd_ptr_wclk = gray2bin(rd_gray_sync);
   assign full = (wr_ptr_spec[pkt_fifo_pkg::ADDR_W] != rd_ptr_wclk[pkt_fifo_pkg::ADDR_W]) &&
                 (wr_ptr_spec[pkt_fifo_pkg::ADDR_W-1:0] == rd_ptr_wclk[pkt_fifo_pkg::ADDR_W-1:0]);

   // ----------------------------------------
   // read side
   // ----------------------------------------

   assign cmt_ptr_rclk = gray2bin(cmt_gray_sync);
   assign rd_avail     = (rd_ptr != cmt_ptr_rclk);

   // pop only when a committed word is there
   assign rd_ptr_nxt = rd_ptr + pkt_fifo_pkg::ptr_t'(rd_en & rd_avail);

   // fall-through head word
   assign rd_data = mem_data[rd_ptr[pkt_fifo_pkg::ADDR_W-1:0]];
   assign rd_keep = mem_keep[rd_ptr[pkt_fifo_pkg::ADDR_W-1:0]];
   assign rd_last = mem_last[rd_ptr[pkt_fifo_pkg::ADDR_W-1:0]];

   always_ff @(posedge clk_out) begin
      if (rst_out) begin
         rd_ptr  <= '0;
         rd_gray <= '0;
      end else begin
         rd_ptr  <= rd_ptr_nxt;
         rd_gray <= bin2gray(rd_ptr_nxt);
      end
   end

   // read pointer back to the write side for the full check
   cdc_sync #(.WIDTH($bits(pkt_fifo_pkg::ptr_t))) i_rd_sync (
      .clk (clk_in),
      .d   (rd_gray),
      .q   (rd_gray_sync)
   );

endmodule

//--- src/pkt_fifo_pkg.sv
package pkt_fifo_pkg;

   // ----------------------------------------
   // buffer geometry
   // ----------------------------------------

   // capacity of the dual-clock buffer in words
   localparam int DEPTH = 16;

   // address bits into buffer memory, log2 of DEPTH
   localparam int ADDR_W = 4;

   // ----------------------------------------
   // packet limits
   // ----------------------------------------

   // longest packet accepted, in words
   // must not exceed DEPTH so a legal packet always fits an empty buffer
   localparam int MAX_PKT_WORDS = 12;

   // ----------------------------------------
   // stream and pointer types
   // ----------------------------------------

   // one data word of the stream
   typedef logic [31:0] word_t;

   // byte valid mask, bit n covers byte n of word_t
   typedef logic [3:0] keep_t;

   // buffer pointer with one extra wrap bit
   // carried in binary or Gray form
   typedef logic [ADDR_W:0] ptr_t;

   // words seen so far in the current packet
   typedef logic [3:0] pkt_len_t;

   // discarded packet count, wraps
   typedef logic [15:0] drop_cnt_t;

endpackage

//--- src/pkt_fifo_top.sv
`timescale 1ns/100ps

module pkt_fifo_top (
   // clk_in domain
   input  logic                    clk_in,
   input  logic                    rst,
   input  logic                    in_valid,
   input  pkt_fifo_pkg::word_t     in_data,
   input  pkt_fifo_pkg::keep_t     in_keep,
   input  logic                    in_last,
   output pkt_fifo_pkg::drop_cnt_t drop_count,

   // clk_out domain
   input  logic                    clk_out,
   output logic                    out_valid,
   input  logic                    out_ready,
   output pkt_fifo_pkg::word_t     out_data,
   output pkt_fifo_pkg::keep_t     out_keep,
   output logic                    out_last
);

   // ingress to buffer
   logic                wr_en;
   pkt_fifo_pkg::word_t wr_data;
   pkt_fifo_pkg::keep_t wr_keep;
   logic                wr_last;
   logic                commit;
   logic                rewind;
   logic                full;

   // buffer to egress
   logic                rd_en;
   logic                rd_avail;
   pkt_fifo_pkg::word_t rd_data;
   pkt_fifo_pkg::keep_t rd_keep;
   logic                rd_last;

   // reset moved into clk_out
   logic                rst_out;

   // ----------------------------------------
   // output side reset
   // ----------------------------------------

   cdc_sync #(.WIDTH(1)) i_rst_sync (
      .clk (clk_out),
      .d   (rst),
      .q   (rst_out)
   );

   // ----------------------------------------
   // producer, buffer, consumer
   // ----------------------------------------

   pkt_ingress i_pkt_ingress (
      .clk_in     (clk_in),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_keep    (in_keep),
      .in_last    (in_last),
      .full       (full),
      .wr_en      (wr_en),
      .wr_data    (wr_data),
      .wr_keep    (wr_keep),
      .wr_last    (wr_last),
      .commit     (commit),
      .rewind     (rewind),
      .drop_count (drop_count)
   );

   pkt_fifo_async i_pkt_fifo_async (
      .clk_in   (clk_in),
      .rst      (rst),
      .wr_en    (wr_en),
      .wr_data  (wr_data),
      .wr_keep  (wr_keep),
      .wr_last  (wr_last),
      .commit   (commit),
      .rewind   (rewind),
      .full     (full),
      .clk_out  (clk_out),
      .rst_out  (rst_out),
      .rd_en    (rd_en),
      .rd_avail (rd_avail),
      .rd_data  (rd_data),
      .rd_keep  (rd_keep),
      .rd_last  (rd_last)
   );

   pkt_egress i_pkt_egress (
      .clk_out   (clk_out),
      .rst_out   (rst_out),
      .rd_avail  (rd_avail),
      .rd_data   (rd_data),
      .rd_keep   (rd_keep),
      .rd_last   (rd_last),
      .rd_en     (rd_en),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data),
      .out_keep  (out_keep),
      .out_last  (out_last)
   );

endmodule

//--- src/pkt_ingress.sv
`timescale 1ns/100ps

module pkt_ingress (
   input  logic                    clk_in,
   input  logic                    rst,

   // incoming stream, no back-pressure
   input  logic                    in_valid,
   input  pkt_fifo_pkg::word_t     in_data,
   input  pkt_fifo_pkg::keep_t     in_keep,
   input  logic                    in_last,

   // buffer status
   input  logic                    full,

   // buffer write port
   output logic                    wr_en,
   output pkt_fifo_pkg::word_t     wr_data,
   output pkt_fifo_pkg::keep_t     wr_keep,
   output logic                    wr_last,
   output logic                    commit,
   output logic                    rewind,

   output pkt_fifo_pkg::drop_cnt_t drop_count
);

   // words taken in the current packet, saturates at the limit
   pkt_fifo_pkg::pkt_len_t word_cnt;

   // current packet already marked bad
   logic dropping;

   // this word would push the packet past the limit
   logic too_long;

   // this word is not written
   logic bad_word;

   // delayed rewind, bumps the counter one cycle later
   logic drop_pulse;

   // ----------------------------------------
   // packet state
   // ----------------------------------------

   assign too_long = (word_cnt == pkt_fifo_pkg::pkt_len_t'(pkt_fifo_pkg::MAX_PKT_WORDS));

   // overflow, oversize, or an earlier word of this packet was lost
   assign bad_word = dropping | full | too_long;

   always_ff @(posedge clk_in) begin
      if (rst) begin
         word_cnt <= '0;
         dropping <= 1'b0;
      end else if (in_valid) begin
         if (in_last) begin
            // next word starts a fresh packet
            word_cnt <= '0;
            dropping <= 1'b0;
         end else begin
            if (!too_long) begin
               word_cnt <= word_cnt + 1'b1;
            end
            if (bad_word) begin
               dropping <= 1'b1;
            end
         end
      end
   end

   // ----------------------------------------
   // buffer write side
   // ----------------------------------------

   // word lands in memory at the same edge it is taken
   assign wr_en   = in_valid & ~bad_word;
   assign wr_data = in_data;
   assign wr_keep = in_keep;
   assign wr_last = in_last;

   // boundary handling on the last word, exactly one of the two fires
   assign commit  = in_valid & in_last & ~bad_word;
   assign rewind  = in_valid & in_last & bad_word;

   // discard counter
   always_ff @(posedge clk_in) begin
      if (rst) begin
         drop_pulse <= 1'b0;
         drop_count <= '0;
      end else begin
         drop_pulse <= rewind;
         if (drop_pulse) begin
            drop_count <= drop_count + 1'b1;
         end
      end
   end

endmodule
